// File: all.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_op_if.sv
verilog/ex_rf_if.sv
verilog/ex_decode.sv
verilog/ex_regfile.sv
verilog/ex_alu.sv
verilog/ex_top.sv
sim/ex_checker.sv
sim/tb_ex.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the verdict.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module tb_ex \
  -f all.f -Mdir obj_dir -o tb_ex

./obj_dir/tb_ex > run.log 2>&1
cat run.log

if grep -q "TESTS PASSED" run.log; then
  exit 0
else
  exit 1
fi

// File: sim/ex_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

// Watches the DUT pins and compares each finished instruction with its expectation.
module ex_checker import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // Issue strobe and DUT outputs.
  input  var logic   i_ex_enc_vld,
  input  var ctr_t   i_ex_ctr,
  input  var logic   i_ex_wr_en,
  input  var reg_t   i_ex_wr_reg,
  input  var slice_t i_ex_wr_data,
  input  var logic   i_ex_pred,

  // Running totals and whether any instruction is still outstanding.
  output var int     o_pass_cnt,
  output var int     o_fail_cnt,
  output var logic   o_busy
);

  // Expectations in issue order, filled by the stimulus side.
  string q_name[$];
  enc_t  q_enc[$];
  byte   q_kind[$];
  data_t q_exp[$];

  // Counter value expected in the cycle that ends at the current edge.
  ctr_t  exp_ctr = '0;

  // Instruction executing in the current slot.
  logic  cur_vld = 1'b0;
  string cur_name;
  enc_t  cur_enc;
  byte   cur_kind;
  data_t cur_exp;
  data_t cur_word;
  int    cur_wr_cnt;
  logic  cur_bad_reg;
  reg_t  cur_seen_reg;

  // Instruction that ended in the previous slot, judged once P has settled.
  logic  done_vld = 1'b0;
  string done_name;
  enc_t  done_enc;
  byte   done_kind;
  data_t done_exp;
  data_t done_word;
  int    done_wr_cnt;
  logic  done_bad_reg;
  reg_t  done_seen_reg;

  initial begin
    o_pass_cnt = 0;
    o_fail_cnt = 0;
    o_busy     = 1'b0;
  end

  // Queues one expectation. Called when the matching encoding is driven.
  task automatic expect_test(input string name, input enc_t enc, input byte kind,
                             input data_t exp);
    q_name.push_back(name);
    q_enc.push_back(enc);
    q_kind.push_back(kind);
    q_exp.push_back(exp);
    o_busy = 1'b1;
  endtask

  // Judges the instruction of the previous slot and prints its line.
  task automatic judge_test();
    logic ok;
    ok = 1'b1;
    case (done_kind)
      "W": begin
        if (done_wr_cnt != 4) begin
          $display("%s: expected four write slices, saw %0d", done_name, done_wr_cnt);
          ok = 1'b0;
        end
        else if (done_bad_reg) begin
          $display("ERR %s write register expected %0d actual %0d",
                   done_name, done_enc[11:8], done_seen_reg);
          ok = 1'b0;
        end
        else if (done_word != done_exp) begin
          $display("ERR %s expected 0x%04h actual 0x%04h", done_name, done_exp, done_word);
          ok = 1'b0;
        end
      end
      "P": begin
        if (done_wr_cnt != 0) begin
          $display("%s: a compare wrote to the register file", done_name);
          ok = 1'b0;
        end
        else if (i_ex_pred != done_exp[0]) begin
          $display("ERR %s expected %0d actual %0d", done_name, done_exp[0], i_ex_pred);
          ok = 1'b0;
        end
      end
      default: begin
        if (done_wr_cnt != 0) begin
          $display("%s: write-back seen for an instruction that must not write", done_name);
          ok = 1'b0;
        end
      end
    endcase
    if (ok) begin
      $display("ok   %s", done_name);
      o_pass_cnt = o_pass_cnt + 1;
    end
    else begin
      o_fail_cnt = o_fail_cnt + 1;
    end
  endtask

  // Outputs are sampled at the rising edge, half a cycle after they settled.
  always @(posedge i_ex_gck) begin
    // The counter sits at 0 in reset and then steps by one every cycle.
    if (i_ex_ctr != exp_ctr) begin
      $display("ERR sync counter expected %0d actual %0d", exp_ctr, i_ex_ctr);
      o_fail_cnt = o_fail_cnt + 1;
    end

    if (!i_ex_rst_n) begin
      cur_vld  = 1'b0;
      done_vld = 1'b0;
      exp_ctr  = '0;
    end
    else begin
      exp_ctr = exp_ctr + ctr_t'(1);

      // A new P is visible from the counter-0 cycle after a compare.
      if (i_ex_ctr == ctr_t'(0) && done_vld) begin
        judge_test();
        done_vld = 1'b0;
      end

      // Collect the write slices of the executing instruction.
      if (i_ex_wr_en) begin
        if (cur_vld) begin
          cur_word[i_ex_ctr*`EX_SLICE_W +: `EX_SLICE_W] = i_ex_wr_data;
          cur_wr_cnt = cur_wr_cnt + 1;
          if (i_ex_wr_reg != cur_enc[11:8]) begin
            cur_bad_reg  = 1'b1;
            cur_seen_reg = i_ex_wr_reg;
          end
        end
        else begin
          $display("Write-back seen while no instruction was executing");
          o_fail_cnt = o_fail_cnt + 1;
        end
      end

      // The slot ends here. The DUT takes the next encoding at this edge.
      if (i_ex_ctr == ctr_t'(3)) begin
        done_vld      = cur_vld;
        done_name     = cur_name;
        done_enc      = cur_enc;
        done_kind     = cur_kind;
        done_exp      = cur_exp;
        done_word     = cur_word;
        done_wr_cnt   = cur_wr_cnt;
        done_bad_reg  = cur_bad_reg;
        done_seen_reg = cur_seen_reg;
        cur_vld       = 1'b0;
        if (i_ex_enc_vld) begin
          if (q_name.size() == 0) begin
            $display("An instruction was issued with no expectation queued");
            o_fail_cnt = o_fail_cnt + 1;
          end
          else begin
            cur_name     = q_name.pop_front();
            cur_enc      = q_enc.pop_front();
            cur_kind     = q_kind.pop_front();
            cur_exp      = q_exp.pop_front();
            cur_word     = '0;
            cur_wr_cnt   = 0;
            cur_bad_reg  = 1'b0;
            cur_seen_reg = '0;
            cur_vld      = 1'b1;
          end
        end
      end
    end
    o_busy = (q_name.size() != 0) || cur_vld || done_vld;
  end

endmodule

`default_nettype wire

// File: sim/ex_vectors.txt
# name encoding(hex) kind expected(hex)
# kind W checks the written word, P the predicate bit, N that nothing is written
movi_r1      51FF W 00FF
movi_r2      5201 W 0001
movi_r0      505A W 005A
add_r0       0301 W 00FF
add_carry    0412 W 0100
sub_wrap     1502 W FFFF
add_wrap     0652 W 0000
movi_r7      57A5 W 00A5
and_op       2857 W 00A5
or_op        3974 W 01A5
xor_op       4A95 W FE5A
ceq_same     6011 P 1
ceq_diff     6012 P 0
cne_diff     7012 P 1
clt_sign     8052 P 1
cltu_sign    9052 P 0
cge_sign     A052 P 0
cgeu_sign    B052 P 1
clt_eq       8011 P 0
cge_eq       A011 P 1
cltu_less    9014 P 1
cgeu_less    B014 P 0
cne_same     7011 P 0
ifnp_pre     D000 N 0
ifnp_run     0C12 W 0100
ifp_pre      C000 N 0
ifp_skip     0D12 N 0
after_skip   0D22 W 0002
ifp_pre2     C000 N 0
cmp_skip     6011 P 0
ifnp_pre2    D000 N 0
ifp_replace  C000 N 0
replace_skip 0E22 N 0
ceq_set      6011 P 1
ifp_pre3     C000 N 0
ifp_run      0E22 W 0002
chain_a      0F12 W 0100
chain_b      0FF2 W 0101
chain_c      1FF1 W 0002
chain_d      4FF5 W FFFD
chain_lt     80F0 P 1
chain_ltu    90F0 P 0
zero_eq      6060 P 1

// File: sim/tb_ex.sv
`timescale 1ns/10ps
`default_nettype none

// Testbench for the execution stage, driven from a vector file.
module tb_ex import ex_pkg::*; ();

  // DUT stimulus.
  logic   gck = 1'b0;
  logic   rst_n;
  enc_t   enc;
  logic   enc_vld;

  // DUT responses.
  ctr_t   ctr;
  logic   wr_en;
  reg_t   wr_reg;
  slice_t wr_data;
  logic   pred;

  // Checker results.
  int     pass_cnt;
  int     fail_cnt;
  logic   busy;

  // Test table, one entry per vector line.
  string  vec_name[$];
  enc_t   vec_enc[$];
  byte    vec_kind[$];
  data_t  vec_exp[$];
  int     n_vec = 0;
  logic   vectors_ready = 1'b0;
  int     read_err = 0;
  integer seed;

  // 100 ns clock period.
  always #50 gck = ~gck;

  ex_top dut (
    .i_ex_gck     (gck),
    .i_ex_rst_n   (rst_n),
    .i_ex_enc     (enc),
    .i_ex_enc_vld (enc_vld),
    .o_ex_ctr     (ctr),
    .o_ex_wr_en   (wr_en),
    .o_ex_wr_reg  (wr_reg),
    .o_ex_wr_data (wr_data),
    .o_ex_pred    (pred)
  );

  ex_checker chk (
    .i_ex_gck     (gck),
    .i_ex_rst_n   (rst_n),
    .i_ex_enc_vld (enc_vld),
    .i_ex_ctr     (ctr),
    .i_ex_wr_en   (wr_en),
    .i_ex_wr_reg  (wr_reg),
    .i_ex_wr_data (wr_data),
    .i_ex_pred    (pred),
    .o_pass_cnt   (pass_cnt),
    .o_fail_cnt   (fail_cnt),
    .o_busy       (busy)
  );

  // Loads the vector file. A line whose first token is # is a comment.
  task automatic read_vectors();
    int fd;
    int code;
    string tok;
    string kind;
    logic [8*160-1:0] rest;
    enc_t e;
    data_t x;
    fd = $fopen("sim/ex_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file sim/ex_vectors.txt");
      read_err = 1;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        break;
      end
      if (tok[0] == "#") begin
        code = $fgets(rest, fd);
      end
      else begin
        code = $fscanf(fd, "%h %s %h", e, kind, x);
        if (code != 3) begin
          $display("Vector line for %s is malformed", tok);
          read_err = 1;
          break;
        end
        vec_name.push_back(tok);
        vec_enc.push_back(e);
        vec_kind.push_back(kind[0]);
        vec_exp.push_back(x);
      end
    end
    $fclose(fd);
    n_vec = vec_name.size();
  endtask

  // Moves to the falling edge inside the next counter-3 cycle.
  task automatic wait_issue_point();
    @(negedge gck);
    while (ctr != ctr_t'(3)) begin
      @(negedge gck);
    end
  endtask

  // Issues one test and hands its expectation to the checker.
  task automatic issue_test(input int idx);
    wait_issue_point();
    chk.expect_test(vec_name[idx], vec_enc[idx], vec_kind[idx], vec_exp[idx]);
    enc     = vec_enc[idx];
    enc_vld = 1'b1;
  endtask

  // Leaves one instruction slot empty.
  task automatic issue_idle();
    wait_issue_point();
    enc_vld = 1'b0;
  endtask

  initial begin
    int gap;
    int i;
    seed    = 30650;
    rst_n   = 1'b0;
    enc     = '0;
    enc_vld = 1'b0;
    read_vectors();
    vectors_ready = 1'b1;
    repeat (10) @(negedge gck);
    rst_n = 1'b1;

    // The first half runs back to back, the second half with random gaps.
    for (i = 0; i < n_vec; i++) begin
      if (i >= n_vec / 2) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) issue_idle();
      end
      issue_test(i);
    end
    issue_idle();
    issue_idle();
    while (busy) begin
      @(negedge gck);
    end

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && read_err == 0 && n_vec > 0 && pass_cnt == n_vec) begin
      $display("TESTS PASSED");
    end
    else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Each test takes at most three slots of four cycles, gaps included.
  initial begin
    wait (vectors_ready);
    #((n_vec * 3 * 4 + 50) * 100);
    $display("Watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

// Slice-serial ALU, flag tracking and the predicate register.
module ex_alu import ex_pkg::*; (
  input  var logic  i_ex_gck,
  input  var logic  i_ex_rst_n,

  ex_op_if.cons     op,
  ex_rf_if.cons     rf,

  // Predicate register written by compares.
  output var logic  o_ex_pred
);

  // Operands for this slice.
  // The right operand is inverted for subtraction.
  slice_t rhs_eff;
  logic   cin;

  // Adder result with its carry out in the top bit.
  logic [`EX_SLICE_W:0] sum;

  // Immediate slice and the final slice result.
  slice_t imm_slice;
  slice_t alu_out;

  // Carry and zero-so-far held between slices.
  logic carry_q;
  logic zero_q;
  logic zero_now;

  // Flags that are meaningful on the last slice.
  logic flag_n;
  logic flag_v;

  // Predicate register.
  logic pred_q;
  logic pred_d;

  // SUB and compares add the inverse plus one, so carry in is set on the
  // first slice. Later slices take the saved carry.
  always_comb begin
    rhs_eff = (op.alu_op == ALU_OP_SUB) ? ~rf.rhs_data : rf.rhs_data;
    cin     = (op.ctr == '0) ? (op.alu_op == ALU_OP_SUB) : carry_q;
    sum     = {1'b0, rf.lhs_data} + {1'b0, rhs_eff} + {{`EX_SLICE_W{1'b0}}, cin};
  end

  always_comb imm_slice = op.imm[op.ctr*`EX_SLICE_W +: `EX_SLICE_W];

  // Slice result for the current operation.
  always_comb begin
    case (op.alu_op)
      ALU_OP_AND:  alu_out = rf.lhs_data & rf.rhs_data;
      ALU_OP_OR:   alu_out = rf.lhs_data | rf.rhs_data;
      ALU_OP_XOR:  alu_out = rf.lhs_data ^ rf.rhs_data;
      ALU_OP_PASS: alu_out = imm_slice;
      default:     alu_out = sum[`EX_SLICE_W-1:0];
    endcase
  end

  // The word is zero only if every slice so far was zero.
  always_comb zero_now = ((op.ctr == '0) ? 1'b1 : zero_q) && (alu_out == '0);

  // Sign and overflow come from the top bit of the slice; they only matter
  // on slice 3.
  always_comb begin
    flag_n = sum[`EX_SLICE_W-1];
    flag_v = (rf.lhs_data[`EX_SLICE_W-1] == rhs_eff[`EX_SLICE_W-1])
          && (sum[`EX_SLICE_W-1] != rf.lhs_data[`EX_SLICE_W-1]);
  end

  // Carry and zero chain from one slice to the next.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      carry_q <= '0;
      zero_q  <= '0;
    end
    else begin
      carry_q <= sum[`EX_SLICE_W];
      zero_q  <= zero_now;
    end
  end

  // New predicate from the flags of the full subtraction.
  always_comb begin
    case (op.cmp_op)
      CMP_OP_NE:  pred_d = !zero_now;
      CMP_OP_LT:  pred_d = flag_n != flag_v;
      CMP_OP_LTU: pred_d = !sum[`EX_SLICE_W];
      CMP_OP_GE:  pred_d = flag_n == flag_v;
      CMP_OP_GEU: pred_d = sum[`EX_SLICE_W];
      default:    pred_d = zero_now;
    endcase
  end

  // P changes at the edge that ends slice 3 of a compare that runs.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= '0;
    end
    else if (op.run && op.cls == CLS_CMP && &op.ctr) begin
      pred_q <= pred_d;
    end
  end

  always_comb o_ex_pred = pred_q;

  // ALU and MOVI results go back to the register file slice by slice.
  always_comb begin
    rf.wr_en   = op.run && op.cls == CLS_ALU;
    rf.wr_reg  = op.dst;
    rf.wr_data = alu_out;
  end

endmodule

`default_nettype wire

// File: verilog/ex_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

// Sync counter, instruction register, decode and predication.
module ex_decode import ex_pkg::*; (
  input  var logic  i_ex_gck,
  input  var logic  i_ex_rst_n,

  // Encoding from the environment, sampled on the last counter cycle.
  input  var enc_t  i_ex_enc,
  input  var logic  i_ex_enc_vld,

  // Current predicate register value.
  input  var logic  i_ex_pred,

  ex_op_if.prod     op,
  ex_rf_if.prod     rf
);

  // Free-running slice counter.
  ctr_t ctr_q;

  // Instruction executing in this group of four cycles.
  enc_t enc_q;
  logic enc_vld_q;

  // Decoded fields of the held encoding.
  logic [3:0] opc;
  cls_t       cls;
  alu_op_t    alu_op;
  cmp_op_t    cmp_op;
  cond_t      cond_new;

  // Predication state and whether it lets the held instruction run.
  cond_t cond_q;
  logic  cond_ok;

  // The counter wraps from 3 back to 0 on its own.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end
    else begin
      ctr_q <= ctr_q + ctr_t'(1);
    end
  end

  // Valid is sampled every counter-3 cycle so an absent instruction leaves
  // an idle slot behind it.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      enc_vld_q <= '0;
    end
    else if (&ctr_q) begin
      enc_vld_q <= i_ex_enc_vld;
    end
  end

  // The encoding itself is only captured when it is valid.
  always_ff @(posedge i_ex_gck) begin
    if (&ctr_q && i_ex_enc_vld) begin
      enc_q <= i_ex_enc;
    end
  end

  always_comb opc = enc_q[15:12];

  // Instruction class.
  // Opcode 14 is unassigned and behaves as a NOP.
  always_comb begin
    case (opc)
      `EX_OPC_ADD, `EX_OPC_SUB, `EX_OPC_AND,
      `EX_OPC_OR, `EX_OPC_XOR, `EX_OPC_MOVI:   cls = CLS_ALU;
      `EX_OPC_CEQ, `EX_OPC_CNE, `EX_OPC_CLT,
      `EX_OPC_CLTU, `EX_OPC_CGE, `EX_OPC_CGEU: cls = CLS_CMP;
      `EX_OPC_IFP, `EX_OPC_IFNP:               cls = CLS_COND;
      `EX_OPC_NOP:                             cls = CLS_NONE;
      default:                                 cls = CLS_NONE;
    endcase
  end

  // ALU operation.
  // Every compare is a subtraction, so SUB is the fallback.
  always_comb begin
    case (opc)
      `EX_OPC_ADD:  alu_op = ALU_OP_ADD;
      `EX_OPC_AND:  alu_op = ALU_OP_AND;
      `EX_OPC_OR:   alu_op = ALU_OP_OR;
      `EX_OPC_XOR:  alu_op = ALU_OP_XOR;
      `EX_OPC_MOVI: alu_op = ALU_OP_PASS;
      default:      alu_op = ALU_OP_SUB;
    endcase
  end

  // Comparison applied to the subtraction flags.
  always_comb begin
    case (opc)
      `EX_OPC_CNE:  cmp_op = CMP_OP_NE;
      `EX_OPC_CLT:  cmp_op = CMP_OP_LT;
      `EX_OPC_CLTU: cmp_op = CMP_OP_LTU;
      `EX_OPC_CGE:  cmp_op = CMP_OP_GE;
      `EX_OPC_CGEU: cmp_op = CMP_OP_GEU;
      default:      cmp_op = CMP_OP_EQ;
    endcase
  end

  // State requested by a prefix, meaningful only for the COND class.
  always_comb cond_new = (opc == `EX_OPC_IFNP) ? COND_IF_NP : COND_IF_P;

  // A pending prefix must match the predicate for the instruction to run.
  always_comb begin
    case (cond_q)
      COND_IF_P:  cond_ok = i_ex_pred;
      COND_IF_NP: cond_ok = !i_ex_pred;
      default:    cond_ok = 1'b1;
    endcase
  end

  // Each retired instruction clears the state, whether it ran or was
  // skipped. A prefix always installs its own state, even over another.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      cond_q <= COND_ALWAYS;
    end
    else if (&ctr_q && enc_vld_q) begin
      cond_q <= (cls == CLS_COND) ? cond_new : COND_ALWAYS;
    end
  end

  // Only ALU and compare instructions do work in the datapath.
  always_comb begin
    op.ctr    = ctr_q;
    op.run    = enc_vld_q && cond_ok && (cls == CLS_ALU || cls == CLS_CMP);
    op.cls    = cls;
    op.alu_op = alu_op;
    op.cmp_op = cmp_op;
    op.dst    = enc_q[11:8];
    op.imm    = data_t'(enc_q[7:0]);
  end

  // Register reads follow the same slice as the ALU.
  always_comb begin
    rf.ctr     = ctr_q;
    rf.lhs_reg = enc_q[7:4];
    rf.rhs_reg = enc_q[3:0];
  end

endmodule

`default_nettype wire

// File: verilog/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Widths of a data word, a slice processed per cycle and the register count.
`define EX_DATA_W  16
`define EX_SLICE_W 4
`define EX_REG_CNT 16

// Opcode values held in the top four bits of an encoding.
`define EX_OPC_ADD  4'd0
`define EX_OPC_SUB  4'd1
`define EX_OPC_AND  4'd2
`define EX_OPC_OR   4'd3
`define EX_OPC_XOR  4'd4
`define EX_OPC_MOVI 4'd5
`define EX_OPC_CEQ  4'd6
`define EX_OPC_CNE  4'd7
`define EX_OPC_CLT  4'd8
`define EX_OPC_CLTU 4'd9
`define EX_OPC_CGE  4'd10
`define EX_OPC_CGEU 4'd11
`define EX_OPC_IFP  4'd12
`define EX_OPC_IFNP 4'd13
`define EX_OPC_NOP  4'd15

`endif

// File: verilog/ex_op_if.sv
`timescale 1ns/10ps
`default_nettype none

// Decoded control for the instruction currently executing.
interface ex_op_if import ex_pkg::*; ();

  // Slice being processed this cycle.
  ctr_t    ctr;

  // High for all four cycles of an instruction that really executes.
  logic    run;

  // Class and operation of the instruction.
  cls_t    cls;
  alu_op_t alu_op;
  cmp_op_t cmp_op;

  // Destination register and zero-extended immediate.
  reg_t    dst;
  data_t   imm;

  // The decoder produces every field.
  modport prod (output ctr, run, cls, alu_op, cmp_op, dst, imm);

  // The ALU only consumes them.
  modport cons (input ctr, run, cls, alu_op, cmp_op, dst, imm);

endinterface

`default_nettype wire

// File: verilog/ex_pkg.sv
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

  // A full data word and the slice of it handled in one cycle.
  typedef logic [`EX_DATA_W-1:0]  data_t;
  typedef logic [`EX_SLICE_W-1:0] slice_t;

  // Register index wide enough to address every register.
  typedef logic [$clog2(`EX_REG_CNT)-1:0] reg_t;

  // Sync counter with one value per slice of a word.
  typedef logic [$clog2(`EX_DATA_W/`EX_SLICE_W)-1:0] ctr_t;

  // Instruction encoding: opcode, dst, lhs and rhs from the top down.
  // MOVI reuses the lower byte as its immediate.
  typedef logic [`EX_DATA_W-1:0] enc_t;

  // Operation performed on each slice by the ALU.
  // PASS forwards the immediate unchanged.
  typedef enum logic [2:0] {
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_AND,
    ALU_OP_OR,
    ALU_OP_XOR,
    ALU_OP_PASS
  } alu_op_t;

  // Comparison used to derive the predicate from the subtraction flags.
  typedef enum logic [2:0] {
    CMP_OP_EQ,
    CMP_OP_NE,
    CMP_OP_LT,
    CMP_OP_LTU,
    CMP_OP_GE,
    CMP_OP_GEU
  } cmp_op_t;

  // Broad class of an instruction.
  typedef enum logic [1:0] {
    CLS_NONE,
    CLS_ALU,
    CLS_CMP,
    CLS_COND
  } cls_t;

  // Predication state set by the IFP and IFNP prefixes.
  typedef enum logic [1:0] {
    COND_ALWAYS,
    COND_IF_P,
    COND_IF_NP
  } cond_t;

endpackage

`default_nettype wire

// File: verilog/ex_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

// Sixteen word register file accessed one slice at a time.
module ex_regfile import ex_pkg::*; (
  input  var logic i_ex_gck,

  ex_rf_if.buff    rf
);

  // Register storage. Entry 0 is never written.
  data_t regs_q [`EX_REG_CNT];

  // Returns the selected slice of a register.
  // Register 0 is hardwired to zero.
  function automatic slice_t read_slice(reg_t idx, ctr_t ctr);
    slice_t data;
    data = '0;
    if (idx != '0) begin
      data = regs_q[idx][ctr*`EX_SLICE_W +: `EX_SLICE_W];
    end
    return data;
  endfunction

  // Both read ports are combinational, so a slice written at one edge is
  // visible to the next instruction in the same slot position.
  always_comb begin
    rf.lhs_data = read_slice(rf.lhs_reg, rf.ctr);
    rf.rhs_data = read_slice(rf.rhs_reg, rf.ctr);
  end

  // One slice is written per cycle.
  // Writes aimed at register 0 are dropped.
  always_ff @(posedge i_ex_gck) begin
    if (rf.wr_en && rf.wr_reg != '0) begin
      regs_q[rf.wr_reg][rf.ctr*`EX_SLICE_W +: `EX_SLICE_W] <= rf.wr_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ex_rf_if.sv
`timescale 1ns/10ps
`default_nettype none

// Slice traffic to and from the register file.
interface ex_rf_if import ex_pkg::*; ();

  // Slice selected for both reads and the write.
  ctr_t   ctr;

  // Read port indices and the slices they return.
  reg_t   lhs_reg;
  reg_t   rhs_reg;
  slice_t lhs_data;
  slice_t rhs_data;

  // Single write port, one slice per cycle.
  logic   wr_en;
  reg_t   wr_reg;
  slice_t wr_data;

  // The decoder selects the slice and the registers to read.
  modport prod (output ctr, lhs_reg, rhs_reg);

  // The register file answers reads and accepts writes.
  modport buff (
    input  ctr, lhs_reg, rhs_reg, wr_en, wr_reg, wr_data,
    output lhs_data, rhs_data
  );

  // The ALU uses the read data and returns its result.
  modport cons (input lhs_data, rhs_data, output wr_en, wr_reg, wr_data);

endinterface

`default_nettype wire

// File: verilog/ex_top.sv
`timescale 1ns/10ps
`default_nettype none

// Execution stage of the nibble-serial processor.
module ex_top import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // Instruction slot, sampled while the counter is 3.
  input  var enc_t   i_ex_enc,
  input  var logic   i_ex_enc_vld,

  // Current slice position.
  output var ctr_t   o_ex_ctr,

  // Register write-back, one slice per cycle.
  output var logic   o_ex_wr_en,
  output var reg_t   o_ex_wr_reg,
  output var slice_t o_ex_wr_data,

  // Predicate register.
  output var logic   o_ex_pred
);

  // Decoded control and register traffic between the units.
  ex_op_if op_bus ();
  ex_rf_if rf_bus ();

  // Predicate fed back to the predication logic.
  logic pred;

  // Counter, instruction register and decode.
  ex_decode decode_u (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_ex_enc     (i_ex_enc),
    .i_ex_enc_vld (i_ex_enc_vld),
    .i_ex_pred    (pred),
    .op           (op_bus),
    .rf           (rf_bus)
  );

  // Register file.
  ex_regfile regfile_u (
    .i_ex_gck (i_ex_gck),
    .rf       (rf_bus)
  );

  // ALU and predicate unit.
  ex_alu alu_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .op         (op_bus),
    .rf         (rf_bus),
    .o_ex_pred  (pred)
  );

  // Internal buses brought out to the pins.
  assign o_ex_ctr     = op_bus.ctr;
  assign o_ex_wr_en   = rf_bus.wr_en;
  assign o_ex_wr_reg  = rf_bus.wr_reg;
  assign o_ex_wr_data = rf_bus.wr_data;
  assign o_ex_pred    = pred;

endmodule

`default_nettype wire
